//--- build.f
fm_index_pkg.sv
fm_ctrl_pkg.sv
fm_table.sv
fm_decode.sv
fm_execute.sv
fm_result.sv
fm_search_top.sv
tb_fm_search.sv

//--- fm_ctrl_pkg.sv
package fm_ctrl_pkg;

    import fm_index_pkg::*;

    // host load targets
    typedef enum logic [1:0] {
        TGT_OCC  = 2'd0,   // occ row, data is a whole occ_entry_t
        TGT_C    = 2'd1,   // c entry addr[1:0], data[6:0]
        TGT_READ = 2'd2    // read base addr[3:0], data[1:0]
    } load_tgt_t;

    // one host write, sampled whenever valid is high
    typedef struct packed {
        logic                           valid;
        load_tgt_t                      tgt;
        logic [OCC_AW-1:0]              addr;
        logic [$bits(occ_entry_t)-1:0]  data;
    } load_t;

    ////////////////////////////////////////////////////////////////////
    // stage records
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        base_t base;    // base applied this step
        logic  first;   // start from the full interval
        logic  last;    // base index 0 of the read
    } search_cmd_t;

    // half open [k, l)
    typedef struct packed {
        pos_t k;
        pos_t l;
    } interval_t;

    typedef struct packed {
        pos_t              k;
        pos_t              l;
        pos_t              count;   // l - k, zero when not found
        logic              found;
        logic [RLEN_W-1:0] steps;   // bases consumed
    } result_t;

endpackage

//--- fm_decode.sv
`timescale 1ns/1ps

module fm_decode import fm_index_pkg::*, fm_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_i,            // host start, four phase
    input  logic [RLEN_W-1:0]  read_len_i,       // 1..16
    input  logic               next_i,           // result says go on
    input  logic               fin_i,            // result says stop
    input  logic               result_ready_i,   // no interval in flight
    input  base_t              base_i,           // read buffer data
    output logic [READ_AW-1:0] base_addr_o,
    output logic               cmd_valid_o,
    output search_cmd_t        cmd_o,
    output logic               busy_o,           // blocks host loads
    output logic               ack_o
);

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for req_i
        ST_FETCH,   // base_i valid, command goes out
        ST_WAIT,    // step in execute / result
        ST_ACK      // result held until req_i drops
    } state_t;

    state_t            state_q;
    logic [RLEN_W-1:0] idx_q;     // base being applied, counts down
    logic              first_q;

    ////////////////////////////////////////////////////////////////////
    // read buffer address
    ////////////////////////////////////////////////////////////////////

    // the fetch overlaps the cycle that accepts req_i or next_i,
    // so every step costs 4 cycles
    always_comb begin
        unique case (state_q)
            ST_IDLE: base_addr_o = READ_AW'(read_len_i - 1'b1);   // last base first
            ST_WAIT: base_addr_o = next_i ? READ_AW'(idx_q - 1'b1) : READ_AW'(idx_q);
            default: base_addr_o = READ_AW'(idx_q);
        endcase
    end

    // command to execute
    always_comb begin
        cmd_o.base  = base_i;
        cmd_o.first = first_q;
        cmd_o.last  = (idx_q == '0);   // base 0 ends the read
    end

    assign cmd_valid_o = (state_q == ST_FETCH);   // one cycle strobe
    assign busy_o      = (state_q != ST_IDLE);
    assign ack_o       = (state_q == ST_ACK);

    ////////////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
            first_q <= 1'b0;
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (req_i && result_ready_i) begin   // ack_o is low here
                        idx_q   <= read_len_i - 1'b1;
                        first_q <= 1'b1;
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    first_q <= 1'b0;   // only the first command starts fresh
                    state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (fin_i) begin
                        state_q <= ST_ACK;
                    end else if (next_i) begin
                        idx_q   <= idx_q - 1'b1;   // walk toward base 0
                        state_q <= ST_FETCH;
                    end
                end
                ST_ACK: begin
                    if (!req_i) begin   // host saw ack, drop it
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- fm_execute.sv
`timescale 1ns/1ps

module fm_execute import fm_index_pkg::*, fm_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    // host writes to the c table
    input  logic              c_we_i,
    input  base_t             c_addr_i,
    input  pos_t              c_data_i,
    // step in
    input  logic              cmd_valid_i,
    input  search_cmd_t       cmd_i,
    input  interval_t         ivl_i,           // interval from the last step
    // occ reads
    output logic [OCC_AW-1:0] occ_addr_k_o,
    output logic [OCC_AW-1:0] occ_addr_l_o,
    input  occ_entry_t        occ_k_i,
    input  occ_entry_t        occ_l_i,
    // step out
    output logic              ivl_valid_o,
    output interval_t         ivl_o
);

    pos_t      c_tab [4];   // C[c] for each base
    interval_t src;         // interval this step starts from
    logic      rd_q;        // occ read in flight
    base_t     base_q;
    logic      k_zero_q;    // Occ(c, 0) is zero with no row behind it
    pos_t      occ_k;
    pos_t      occ_l;

    // pick one base's count out of an occ row
    function automatic pos_t occ_count(occ_entry_t row, base_t b);
        pos_t cnt;
        unique case (b)
            BASE_A: cnt = row.cnt_a;
            BASE_C: cnt = row.cnt_c;
            BASE_G: cnt = row.cnt_g;
            BASE_T: cnt = row.cnt_t;
        endcase
        return cnt;
    endfunction

    always_ff @(posedge clk) begin
        if (c_we_i) begin
            c_tab[c_addr_i] <= c_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // cycle 1 sends the occ addresses
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cmd_i.first) begin
            src.k = '0;                 // full range
            src.l = pos_t'(OCC_DEPTH);
        end else begin
            src = ivl_i;
        end
    end

    // Occ(c, x) lives in row x-1
    assign occ_addr_k_o = OCC_AW'(src.k - 1'b1);
    assign occ_addr_l_o = OCC_AW'(src.l - 1'b1);

    always_ff @(posedge clk) begin
        base_q   <= cmd_i.base;
        k_zero_q <= (src.k == '0);
    end

    ////////////////////////////////////////////////////////////////////
    // cycle 2 adds C[c] to the returned counts
    ////////////////////////////////////////////////////////////////////

    assign occ_k = k_zero_q ? '0 : occ_count(occ_k_i, base_q);
    assign occ_l = occ_count(occ_l_i, base_q);

    always_ff @(posedge clk) begin
        ivl_o.k <= c_tab[base_q] + occ_k;   // new_k = C[c] + Occ(c, k)
        ivl_o.l <= c_tab[base_q] + occ_l;   // new_l = C[c] + Occ(c, l)
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_q        <= 1'b0;
            ivl_valid_o <= 1'b0;
        end else begin
            rd_q        <= cmd_valid_i;
            ivl_valid_o <= rd_q;   // 2 cycles after cmd_valid_i
        end
    end

endmodule

//--- fm_index_pkg.sv
package fm_index_pkg;

    ////////////////////////////////////////////////////////////////////
    // index geometry
    ////////////////////////////////////////////////////////////////////

    localparam int OCC_DEPTH  = 64;                  // occ rows = bwt length
    localparam int OCC_AW     = $clog2(OCC_DEPTH);   // occ row address
    localparam int POS_W      = 7;                   // holds OCC_DEPTH itself
    localparam int READ_DEPTH = 16;                  // bases per read
    localparam int READ_AW    = $clog2(READ_DEPTH);  // read buffer address
    localparam int RLEN_W     = 5;                   // read length 1..16

    // nucleotide codes
    typedef logic [1:0] base_t;

    localparam base_t BASE_A = 2'd0;
    localparam base_t BASE_C = 2'd1;
    localparam base_t BASE_G = 2'd2;
    localparam base_t BASE_T = 2'd3;

    // suffix array interval bound
    typedef logic [POS_W-1:0] pos_t;

    ////////////////////////////////////////////////////////////////////
    // occ table row
    ////////////////////////////////////////////////////////////////////

    // row i counts each base over bwt[0..i], both ends included
    // so Occ(c, x) is row x-1 for x > 0 and zero for x == 0
    // cnt_a sits in the low bits, matching load data[6:0]
    typedef struct packed {
        pos_t cnt_t;
        pos_t cnt_g;
        pos_t cnt_c;
        pos_t cnt_a;
    } occ_entry_t;

endpackage

//--- fm_result.sv
`timescale 1ns/1ps

module fm_result import fm_index_pkg::*, fm_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,       // first command of a search
    input  logic      ivl_valid_i,
    input  interval_t ivl_i,
    input  logic      last_i,        // this step applied base 0
    output interval_t ivl_o,         // running interval back to execute
    output logic      next_o,
    output logic      fin_o,
    output result_t   result_o
);

    logic [RLEN_W-1:0] steps_q;
    logic [RLEN_W-1:0] steps_nxt;
    logic              empty;
    logic              done;

    assign steps_nxt = steps_q + 1'b1;
    assign empty     = (ivl_i.k >= ivl_i.l);   // no suffix left
    assign done      = empty | last_i;

    // running interval, payload only
    always_ff @(posedge clk) begin
        if (start_i) begin
            ivl_o.k <= '0;
            ivl_o.l <= pos_t'(OCC_DEPTH);
        end else if (ivl_valid_i) begin
            ivl_o <= ivl_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            steps_q  <= '0;
            next_o   <= 1'b0;
            fin_o    <= 1'b0;
            result_o <= '0;
        end else begin
            next_o <= ivl_valid_i & ~done;   // strobes
            fin_o  <= ivl_valid_i & done;
            if (start_i) begin
                steps_q <= '0;
            end else if (ivl_valid_i) begin
                steps_q <= steps_nxt;
                if (done) begin   // held until the next search ends
                    result_o.k     <= ivl_i.k;
                    result_o.l     <= ivl_i.l;
                    result_o.found <= ~empty;
                    result_o.count <= empty ? '0 : pos_t'(ivl_i.l - ivl_i.k);
                    result_o.steps <= steps_nxt;
                end
            end
        end
    end

endmodule

//--- fm_search_top.sv
`timescale 1ns/1ps

module fm_search_top import fm_index_pkg::*, fm_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  load_t             load_i,       // host table writes
    input  logic              req_i,
    input  logic [RLEN_W-1:0] read_len_i,
    output logic              ack_o,
    output result_t           result_o
);

    // host load routing
    logic load_ok;
    logic occ_we;
    logic c_we;
    logic read_we;

    // decode <-> read buffer
    logic [READ_AW-1:0] base_addr;
    base_t              base;

    // stage links
    logic              busy;
    logic              cmd_valid;
    search_cmd_t       cmd;
    logic              start;
    logic [OCC_AW-1:0] occ_addr_k;
    logic [OCC_AW-1:0] occ_addr_l;
    occ_entry_t        occ_k;
    occ_entry_t        occ_l;
    logic              ivl_valid;
    interval_t         ivl_new;    // execute -> result
    interval_t         ivl_cur;    // result -> execute
    logic              next;
    logic              fin;

    ////////////////////////////////////////////////////////////////////
    // load decode, dropped while a search runs
    ////////////////////////////////////////////////////////////////////

    assign load_ok = load_i.valid & ~busy;
    assign occ_we  = load_ok & (load_i.tgt == TGT_OCC);
    assign c_we    = load_ok & (load_i.tgt == TGT_C);
    assign read_we = load_ok & (load_i.tgt == TGT_READ);

    assign start = cmd_valid & cmd.first;   // result restarts its interval

    fm_table #(.entry_t(occ_entry_t), .DEPTH(OCC_DEPTH)) u_occ (
        .clk       (clk),
        .we_i      (occ_we),
        .waddr_i   (load_i.addr),
        .wdata_i   (occ_entry_t'(load_i.data)),
        .raddr_a_i (occ_addr_k),   // Occ(c, k)
        .raddr_b_i (occ_addr_l),   // Occ(c, l)
        .rdata_a_o (occ_k),
        .rdata_b_o (occ_l)
    );

    fm_table #(.entry_t(base_t), .DEPTH(READ_DEPTH)) u_read (
        .clk       (clk),
        .we_i      (read_we),
        .waddr_i   (load_i.addr[READ_AW-1:0]),
        .wdata_i   (load_i.data[1:0]),
        .raddr_a_i (base_addr),
        .raddr_b_i ('0),           // port b idle
        .rdata_a_o (base),
        .rdata_b_o ()
    );

    fm_decode u_decode (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .read_len_i     (read_len_i),
        .next_i         (next),
        .fin_i          (fin),
        .result_ready_i (~ivl_valid),
        .base_i         (base),
        .base_addr_o    (base_addr),
        .cmd_valid_o    (cmd_valid),
        .cmd_o          (cmd),
        .busy_o         (busy),
        .ack_o          (ack_o)
    );

    fm_execute u_execute (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .c_we_i       (c_we),
        .c_addr_i     (load_i.addr[1:0]),
        .c_data_i     (load_i.data[POS_W-1:0]),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .ivl_i        (ivl_cur),
        .occ_addr_k_o (occ_addr_k),
        .occ_addr_l_o (occ_addr_l),
        .occ_k_i      (occ_k),
        .occ_l_i      (occ_l),
        .ivl_valid_o  (ivl_valid),
        .ivl_o        (ivl_new)
    );

    fm_result u_result (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start),
        .ivl_valid_i (ivl_valid),
        .ivl_i       (ivl_new),
        .last_i      (cmd.last),   // idx holds until next, still valid here
        .ivl_o       (ivl_cur),
        .next_o      (next),
        .fin_o       (fin),
        .result_o    (result_o)
    );

endmodule

//--- fm_table.sv
`timescale 1ns/1ps

// one write port, two registered read ports
module fm_table #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_a_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_b_i,
    output entry_t                   rdata_a_o,
    output entry_t                   rdata_b_o
);

    entry_t mem [DEPTH];   // no reset, host loads before use

    // host write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // both reads land one cycle after the address
    always_ff @(posedge clk) begin
        rdata_a_o <= mem[raddr_a_i];
        rdata_b_o <= mem[raddr_b_i];   // old data on a same-cycle write
    end

endmodule

//--- tb_fm_search.sv
`timescale 1ns/1ps

module tb_fm_search import fm_index_pkg::*, fm_ctrl_pkg::*; ();

    localparam int ACK_TIMEOUT  = 4 * READ_DEPTH + 20;  // 4 cycles per step + slack
    localparam int DROP_TIMEOUT = 4;
    localparam int TEXT_LEN     = OCC_DEPTH - 1;        // bases before the sentinel

    logic              clk = 1'b0;
    logic              arst_n;
    load_t             load;
    logic              req;
    logic [RLEN_W-1:0] read_len;
    logic              ack;
    result_t           result;

    // reference index, symbols 0 = sentinel, 1..4 = base + 1
    logic [2:0]  text [OCC_DEPTH];
    logic [2:0]  bwt [OCC_DEPTH];
    int          sa [OCC_DEPTH];
    int          c_ref [4];
    base_t       rd [READ_DEPTH];      // current read
    logic [31:0] lfsr_q = 32'h2a11_24a6;

    int      errors;
    int      timeouts;
    int      ref_steps;   // model steps of the last search
    int      early;       // searches that went empty early
    result_t last_res;
    int      n;
    int      len;
    int      start;

    always #2 clk = ~clk;   // 4 ns period

    fm_search_top u_fm_search_top (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .load_i     (load),
        .req_i      (req),
        .read_len_i (read_len),
        .ack_o      (ack),
        .result_o   (result)
    );

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns %s", $time, msg);
    endtask

    // rotation order, sentinel is unique so the walk always ends
    function automatic bit suffix_less(input int a, input int b);
        int i;
        for (i = 0; i < OCC_DEPTH; i++) begin
            if (text[(a + i) % OCC_DEPTH] != text[(b + i) % OCC_DEPTH]) begin
                return text[(a + i) % OCC_DEPTH] < text[(b + i) % OCC_DEPTH];
            end
        end
        return 1'b0;
    endfunction

    // count of base c in bwt[0..x-1]
    function automatic int occ_ref(input int c, input int x);
        int cnt;
        cnt = 0;
        for (int i = 0; i < x; i++) begin
            cnt += (bwt[i] == 3'(c + 1));
        end
        return cnt;
    endfunction

    function automatic int text_total(input int c);
        int cnt;
        cnt = 0;
        for (int i = 0; i < TEXT_LEN; i++) begin
            cnt += (text[i] == 3'(c + 1));
        end
        return cnt;
    endfunction

    // random text + sentinel, sorted rotations give the bwt
    task automatic build_index();
        int j;
        int tmp;
        for (int i = 0; i < TEXT_LEN; i++) begin
            text[i] = 3'(1 + rand_bits(2));
        end
        text[TEXT_LEN] = 3'd0;
        for (int i = 0; i < OCC_DEPTH; i++) begin
            sa[i] = i;
        end
        for (int i = 1; i < OCC_DEPTH; i++) begin   // insertion sort
            j = i;
            while (j > 0 && suffix_less(sa[j], sa[j-1])) begin
                tmp     = sa[j];
                sa[j]   = sa[j-1];
                sa[j-1] = tmp;
                j--;
            end
        end
        for (int i = 0; i < OCC_DEPTH; i++) begin
            bwt[i] = text[(sa[i] + OCC_DEPTH - 1) % OCC_DEPTH];
        end
        c_ref[0] = 1;   // sentinel sorts first
        for (int c = 1; c < 4; c++) begin
            c_ref[c] = c_ref[c-1] + text_total(c - 1);
        end
    endtask

    // backward search straight from the interval rule
    task automatic search_ref(input int rlen, output int k, output int l, output int steps);
        int c;
        k     = 0;
        l     = OCC_DEPTH;
        steps = 0;
        for (int i = rlen - 1; i >= 0; i--) begin
            c = rd[i];
            k = c_ref[c] + occ_ref(c, k);
            l = c_ref[c] + occ_ref(c, l);
            steps++;
            if (k >= l) break;   // empty interval
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////

    // one write per cycle, called right after a falling edge
    task automatic load_write(input load_tgt_t tgt, input int addr,
                              input logic [$bits(occ_entry_t)-1:0] data);
        load.valid = 1'b1;
        load.tgt   = tgt;
        load.addr  = OCC_AW'(addr);
        load.data  = data;
        @(negedge clk);
        load.valid = 1'b0;
    endtask

    task automatic load_tables();
        occ_entry_t row;
        row = '0;
        for (int i = 0; i < OCC_DEPTH; i++) begin
            case (bwt[i])   // running counts, sentinel adds nothing
                3'd1: row.cnt_a++;
                3'd2: row.cnt_c++;
                3'd3: row.cnt_g++;
                3'd4: row.cnt_t++;
                default: ;
            endcase
            load_write(TGT_OCC, i, row);
        end
        for (int c = 0; c < 4; c++) begin
            load_write(TGT_C, c, c_ref[c]);
        end
    endtask

    task automatic load_read(input int rlen);
        for (int i = 0; i < rlen; i++) begin
            load_write(TGT_READ, i, rd[i]);
        end
    endtask

    // one four phase search, optionally with occ writes that must be dropped
    task automatic run_search(input int rlen, input bit corrupt);
        int      k_exp;
        int      l_exp;
        int      cnt;
        int      hold;
        result_t snap;
        if (timeouts != 0) return;   // dut already stuck
        search_ref(rlen, k_exp, l_exp, ref_steps);
        read_len = RLEN_W'(rlen);
        req      = 1'b1;
        @(negedge clk);
        if (corrupt) begin
            load_write(TGT_OCC, OCC_DEPTH - 1, rand_bits(28));   // row of the full range
            load_write(TGT_OCC, rand_bits(6), rand_bits(28));
            load_write(TGT_OCC, rand_bits(6), rand_bits(28));
        end
        cnt = 0;
        while (ack !== 1'b1 && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== 1'b1) begin
            $display("timeout: ack_o did not rise within %0d cycles", ACK_TIMEOUT);
            timeouts++;
            return;
        end
        assert (result.k == pos_t'(k_exp) && result.l == pos_t'(l_exp))
            else flag_error($sformatf("interval [%0d,%0d), expected [%0d,%0d)",
                                      result.k, result.l, k_exp, l_exp));
        assert (result.found == (k_exp < l_exp))
            else flag_error($sformatf("found %0b, expected %0b", result.found, k_exp < l_exp));
        assert (result.count == pos_t'((k_exp < l_exp) ? l_exp - k_exp : 0))
            else flag_error($sformatf("count %0d for [%0d,%0d)", result.count, k_exp, l_exp));
        assert (result.steps == RLEN_W'(ref_steps))
            else flag_error($sformatf("steps %0d, expected %0d", result.steps, ref_steps));
        snap = result;
        hold = rand_bits(2);   // host is slow to drop req
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            assert (ack === 1'b1 && result === snap)
                else flag_error("ack_o or result_o moved while req_i high");
        end
        req = 1'b0;
        cnt = 0;
        while (ack === 1'b1 && cnt < DROP_TIMEOUT) begin
            assert (result === snap) else flag_error("result_o changed while ack_o high");
            @(negedge clk);
            cnt++;
        end
        if (ack === 1'b1) begin
            $display("timeout: ack_o stayed high after req_i fell");
            timeouts++;
        end
        last_res = snap;
    endtask

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin
        errors   = 0;
        timeouts = 0;
        early    = 0;
        arst_n   = 1'b0;
        req      = 1'b0;
        read_len = RLEN_W'(1);
        load     = '0;
        build_index();
        repeat (10) @(negedge clk);
        assert (ack === 1'b0 && result === '0) else flag_error("outputs not cleared in reset");
        arst_n = 1'b1;
        @(negedge clk);
        assert (ack === 1'b0 && result === '0) else flag_error("outputs not zero after reset");
        load_tables();

        // single bases give [C[c], C[c] + total)
        for (int c = 0; c < 4; c++) begin
            rd[0] = base_t'(c);
            load_read(1);
            run_search(1, 1'b0);
            assert (last_res.k == pos_t'(c_ref[c]) &&
                    last_res.l == pos_t'(c_ref[c] + text_total(c)))
                else flag_error($sformatf("base %0d gives [%0d,%0d)", c, last_res.k, last_res.l));
        end

        // substrings of the text must be found
        for (n = 0; n < 8; n++) begin
            len   = 1 + rand_bits(4);
            start = rand_bits(6) % (OCC_DEPTH - len);
            for (int i = 0; i < len; i++) begin
                rd[i] = base_t'(text[start + i] - 1);
            end
            load_read(len);
            run_search(len, 1'b0);
            assert (last_res.found && last_res.count >= 1)
                else flag_error($sformatf("substring at %0d len %0d not found", start, len));
        end

        // random reads, long ones mostly die early
        for (n = 0; n < 16; n++) begin
            len = (n < 8) ? 1 + rand_bits(4) : READ_DEPTH;
            for (int i = 0; i < len; i++) begin
                rd[i] = rand_bits(2);
            end
            load_read(len);
            run_search(len, 1'b0);
            if (ref_steps < len) begin
                early++;
                assert (last_res.steps < RLEN_W'(len))
                    else flag_error($sformatf("steps %0d not below %0d", last_res.steps, len));
            end
        end

        // occ writes mid search are dropped, next search sees clean table
        for (n = 0; n < 3; n++) begin
            len   = 4 + rand_bits(3);
            start = rand_bits(6) % (OCC_DEPTH - len);
            for (int i = 0; i < len; i++) begin
                rd[i] = base_t'(text[start + i] - 1);
            end
            load_read(len);
            run_search(len, 1'b1);
            run_search(len, 1'b0);
        end

        $display("errors %0d, timeouts %0d, early exits %0d", errors, timeouts, early);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
